// File: verilog/aes_pkg.sv
/* AES-128 engine shared package
 * Control types, register map, mode codes, GF(2^8) helper and S-box
 */
`default_nettype none

package aes_pkg;

	// ===================================================================
	// Modes and control word
	// ===================================================================

	// Chaining mode, codes 1 and 3 are unsupported
	typedef enum logic [1:0] {
		ECB = 2'b00,
		CTR = 2'b10
	} aes_mode_e;

	// CR seen as a bus word or as its fields
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [27:0] rsvd;
			aes_mode_e   mode;
			logic        disable_core;
			logic        start;
		} fields;
	} aes_cr_u;

	// Shared S-box bank input source
	typedef enum logic [2:0] {
		COL_0      = 3'b000,
		COL_1      = 3'b001,
		COL_2      = 3'b010,
		COL_3      = 3'b011,
		G_FUNCTION = 3'b100
	} aes_sbox_sel_e;

	// Commands from the sequencer to datapath and key schedule
	typedef struct packed {
		aes_sbox_sel_e sbox_sel;
		logic          load_input;
		logic          add_key_only;
		logic [3:0]    col_en;
		logic          last_round;
		logic          commit;
		logic          key_step;
		logic          key_load;
	} aes_ctrl_t;

	// ===================================================================
	// Register map, word addresses, word 0 is the most significant
	// ===================================================================
	localparam logic [4:0] REG_CR    = 5'd0;
	localparam logic [4:0] REG_SR    = 5'd1;
	localparam logic [4:0] REG_DIN0  = 5'd2;
	localparam logic [4:0] REG_DIN1  = 5'd3;
	localparam logic [4:0] REG_DIN2  = 5'd4;
	localparam logic [4:0] REG_DIN3  = 5'd5;
	localparam logic [4:0] REG_DOUT0 = 5'd6;
	localparam logic [4:0] REG_DOUT1 = 5'd7;
	localparam logic [4:0] REG_DOUT2 = 5'd8;
	localparam logic [4:0] REG_DOUT3 = 5'd9;
	localparam logic [4:0] REG_KEY0  = 5'd10;
	localparam logic [4:0] REG_KEY1  = 5'd11;
	localparam logic [4:0] REG_KEY2  = 5'd12;
	localparam logic [4:0] REG_KEY3  = 5'd13;
	localparam logic [4:0] REG_IV0   = 5'd14;
	localparam logic [4:0] REG_IV1   = 5'd15;
	localparam logic [4:0] REG_IV2   = 5'd16;
	localparam logic [4:0] REG_IV3   = 5'd17;

	// AES-128 round count
	localparam logic [3:0] NUM_ROUNDS = 4'd10;

	// First round constant, later ones by doubling
	localparam logic [7:0] RCON_INIT = 8'h01;

	// Multiply by x in GF(2^8), polynomial 0x11b
	function automatic logic [7:0] gf_xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// ===================================================================
	// Forward S-box, entry 0 first
	// ===================================================================
	localparam logic [0:255][7:0] SBOX_TABLE = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	function automatic logic [7:0] aes_sbox(input logic [7:0] b);
		return SBOX_TABLE[b];
	endfunction

endpackage

`default_nettype wire

// File: verilog/aes_host_regs.sv
/* AES host register file
 * Wishbone classic slave with CR, SR, DIN, DOUT, KEY and IV words
 */
`default_nettype none

module aes_host_regs #(
	parameter int ADDR_W = 5
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               cyc,
	input  logic               stb,
	input  logic               we,
	input  logic [ADDR_W-1:0]  adr,
	input  logic [31:0]        dat_w,
	input  logic               end_comp,
	input  logic [127:0]       cipher_out,
	input  logic               iv_cnt_en,
	output logic [31:0]        dat_r,
	output logic               ack,
	output logic               start,
	output logic               disable_core,
	output aes_pkg::aes_mode_e mode,
	output logic [127:0]       block_in,
	output logic [127:0]       key_in,
	output logic [127:0]       iv_in
);
	import aes_pkg::*;

	// Bus side
	logic req;
	logic wr;
	logic cr_hit;
	logic start_set;
	logic [31:0] rd_data;

	// Control word views
	aes_cr_u wr_cr;
	aes_cr_u cr_wr_val;
	aes_cr_u cr_q;

	// Status
	logic busy;
	logic done;

	// Block registers, index 0 holds bits 127:96
	logic [0:3][31:0] din_q;
	logic [0:3][31:0] key_q;
	logic [0:3][31:0] iv_q;
	logic [0:3][31:0] dout_q;

	// Request seen, ack goes out next clock and blocks a second one
	assign req = cyc & stb & ~ack;
	assign wr = req & we;
	assign cr_hit = (adr == ADDR_W'(REG_CR));

	assign wr_cr.raw = dat_w;

	// Start never stored, reserved bits forced to zero
	always_comb
	begin
		cr_wr_val.raw = '0;
		cr_wr_val.fields.disable_core = wr_cr.fields.disable_core;
		cr_wr_val.fields.mode = wr_cr.fields.mode;
	end

	// Start dropped while busy or when the same write disables the core
	assign start_set = wr & cr_hit & wr_cr.fields.start & ~wr_cr.fields.disable_core & ~busy;

	assign disable_core = cr_q.fields.disable_core;
	assign mode = cr_q.fields.mode;
	assign block_in = din_q;
	assign key_in = key_q;
	assign iv_in = iv_q;

	// ===================================================================
	// Handshake, control and status
	// ===================================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ack <= 1'b0;
			start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			cr_q <= '0;
		end
		else
		begin
			ack <= req;
			start <= start_set;
			if (wr && cr_hit)
				cr_q <= cr_wr_val;
			// Abort through disable_core also frees the engine
			if (start_set)
				busy <= 1'b1;
			else if (end_comp || disable_core)
				busy <= 1'b0;
			// Done sticks until the next accepted start
			if (start_set)
				done <= 1'b0;
			else if (end_comp)
				done <= 1'b1;
		end
	end

	// ===================================================================
	// Data words
	// ===================================================================
	always_ff @(posedge clk)
	begin
		// CTR result is the keystream applied to the data block
		if (end_comp)
			dout_q <= (mode == CTR) ? (cipher_out ^ block_in) : cipher_out;
		if (wr && !busy)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (adr == ADDR_W'(REG_DIN0 + i))
					din_q[i] <= dat_w;
				if (adr == ADDR_W'(REG_KEY0 + i))
					key_q[i] <= dat_w;
				if (adr == ADDR_W'(REG_IV0 + i))
					iv_q[i] <= dat_w;
			end
		end
		// Full 128-bit counter, carries across words
		if (iv_cnt_en)
			iv_q <= iv_q + 128'd1;
		if (req)
			dat_r <= rd_data;
	end

	// Read mux, unmapped words read zero
	always_comb
	begin
		rd_data = '0;
		if (cr_hit)
			rd_data = cr_q.raw;
		if (adr == ADDR_W'(REG_SR))
			rd_data = {30'd0, done, busy};
		for (int i = 0; i < 4; i++)
		begin
			if (adr == ADDR_W'(REG_DIN0 + i))
				rd_data = din_q[i];
			if (adr == ADDR_W'(REG_DOUT0 + i))
				rd_data = dout_q[i];
			if (adr == ADDR_W'(REG_KEY0 + i))
				rd_data = key_q[i];
			if (adr == ADDR_W'(REG_IV0 + i))
				rd_data = iv_q[i];
		end
	end

endmodule

`default_nettype wire

// File: verilog/aes_control_unit.sv
/* AES encryption sequencer
 * Steps round 0, then ten rounds of key step plus four column cycles
 */
`default_nettype none

module aes_control_unit (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic               disable_core,
	input  aes_pkg::aes_mode_e mode,
	output aes_pkg::aes_ctrl_t ctrl,
	output logic               end_comp,
	output logic               iv_cnt_en
);
	import aes_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ROUND0,
		ST_KEY,
		ST_COL0,
		ST_COL1,
		ST_COL2,
		ST_COL3,
		ST_READY
	} state_e;

	state_e state_q;
	state_e state_next;
	logic [3:0] round_q;
	logic last_round;

	// Counter holds the number of the round being worked on
	assign last_round = (round_q == NUM_ROUNDS);

	// ===================================================================
	// State register and round counter
	// ===================================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state_q <= ST_IDLE;
		else if (disable_core)
			state_q <= ST_IDLE;
		else
			state_q <= state_next;
	end

	// Bumped in each key step, cleared while idle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			round_q <= '0;
		else if (state_q == ST_IDLE)
			round_q <= '0;
		else if (state_q == ST_KEY)
			round_q <= round_q + 4'd1;
	end

	// Next state
	always_comb
	begin
		state_next = state_q;
		case (state_q)
			ST_IDLE:
				if (start)
					state_next = ST_ROUND0;
			ST_ROUND0:
				state_next = ST_KEY;
			ST_KEY:
				state_next = ST_COL0;
			ST_COL0:
				state_next = ST_COL1;
			ST_COL1:
				state_next = ST_COL2;
			ST_COL2:
				state_next = ST_COL3;
			ST_COL3:
				state_next = last_round ? ST_READY : ST_KEY;
			ST_READY:
				state_next = ST_IDLE;
			default:
				state_next = ST_IDLE;
		endcase
	end

	// ===================================================================
	// Command decode
	// ===================================================================
	always_comb
	begin
		ctrl = '0;
		ctrl.last_round = last_round;
		case (state_q)
			// Block and key captured on the start cycle
			ST_IDLE:
			begin
				ctrl.load_input = start;
				ctrl.key_load = start;
			end
			ST_ROUND0:
				ctrl.add_key_only = 1'b1;
			// S-box bank lent to the g function
			ST_KEY:
			begin
				ctrl.sbox_sel = G_FUNCTION;
				ctrl.key_step = 1'b1;
			end
			ST_COL0:
			begin
				ctrl.sbox_sel = COL_0;
				ctrl.col_en = 4'b0001;
			end
			ST_COL1:
			begin
				ctrl.sbox_sel = COL_1;
				ctrl.col_en = 4'b0010;
			end
			ST_COL2:
			begin
				ctrl.sbox_sel = COL_2;
				ctrl.col_en = 4'b0100;
			end
			// Last column also moves the shadow into the state
			ST_COL3:
			begin
				ctrl.sbox_sel = COL_3;
				ctrl.col_en = 4'b1000;
				ctrl.commit = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	assign end_comp = (state_q == ST_READY);
	assign iv_cnt_en = (state_q == ST_READY) && (mode == CTR);

endmodule

`default_nettype wire

// File: verilog/aes_key_schedule.sv
/* AES-128 round key expansion
 * One round key per step, substitution done in the shared S-box bank
 */
`default_nettype none

module aes_key_schedule (
	input  logic               clk,
	input  logic               rst_n,
	input  aes_pkg::aes_ctrl_t ctrl,
	input  logic [127:0]       key_in,
	input  logic [31:0]        sbox_out,
	output logic [127:0]       round_key,
	output logic [31:0]        g_word
);
	import aes_pkg::*;

	logic [7:0] rcon_q;
	logic [31:0] temp;
	logic [31:0] w0;
	logic [31:0] w1;
	logic [31:0] w2;
	logic [31:0] w3;

	// RotWord of the last key word
	assign g_word = {round_key[23:0], round_key[31:24]};

	// SubWord result with the round constant on the top byte
	assign temp = sbox_out ^ {rcon_q, 24'h000000};

	// Each new word chains off the one before it
	assign w0 = round_key[127:96] ^ temp;
	assign w1 = round_key[95:64] ^ w0;
	assign w2 = round_key[63:32] ^ w1;
	assign w3 = round_key[31:0] ^ w2;

	// Round constant
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rcon_q <= RCON_INIT;
		else if (ctrl.key_load)
			rcon_q <= RCON_INIT;
		else if (ctrl.key_step)
			rcon_q <= gf_xtime(rcon_q);
	end

	// Current round key, cipher key after load
	always_ff @(posedge clk)
	begin
		if (ctrl.key_load)
			round_key <= key_in;
		else if (ctrl.key_step)
			round_key <= {w0, w1, w2, w3};
	end

endmodule

`default_nettype wire

// File: verilog/aes_round_datapath.sv
/* AES round datapath
 * State and shadow registers, one column of round logic per cycle
 */
`default_nettype none

module aes_round_datapath (
	input  logic               clk,
	input  logic               rst_n,
	input  aes_pkg::aes_ctrl_t ctrl,
	input  logic [127:0]       block_in,
	input  logic [127:0]       iv_in,
	input  aes_pkg::aes_mode_e mode,
	input  logic [127:0]       round_key,
	input  logic [31:0]        g_word,
	output logic [31:0]        sbox_out,
	output logic [127:0]       cipher_out
);
	import aes_pkg::*;

	logic [127:0] state_q;
	logic [127:0] shadow_q;
	logic [127:0] shadow_next;
	logic [1:0] col_idx;
	logic [31:0] sr_col;
	logic [31:0] sbox_in;
	logic [31:0] rk_col;
	logic [31:0] new_col;

	// Byte at column c, row r, byte 0 in the top bits
	function automatic logic [7:0] get_byte(input logic [127:0] s, input int c, input int r);
		return s[127 - 8 * (4 * c + r) -: 8];
	endfunction

	// Fixed matrix 02 03 01 01, rotated per row
	function automatic logic [31:0] mix_column(input logic [31:0] c);
		logic [7:0] a0;
		logic [7:0] a1;
		logic [7:0] a2;
		logic [7:0] a3;
		a0 = c[31:24];
		a1 = c[23:16];
		a2 = c[15:8];
		a3 = c[7:0];
		return {
			gf_xtime(a0) ^ gf_xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ gf_xtime(a1) ^ gf_xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ gf_xtime(a2) ^ gf_xtime(a3) ^ a3,
			gf_xtime(a0) ^ a0 ^ a1 ^ a2 ^ gf_xtime(a3)
		};
	endfunction

	// Low select bits name the output column
	assign col_idx = ctrl.sbox_sel[1:0];

	// ShiftRows, row r comes from column c + r
	always_comb
	begin
		for (int r = 0; r < 4; r++)
			sr_col[31 - 8 * r -: 8] = get_byte(state_q, (int'(col_idx) + r) % 4, r);
	end

	// Shared bank, four lookups
	assign sbox_in = (ctrl.sbox_sel == G_FUNCTION) ? g_word : sr_col;
	assign sbox_out = {
		aes_sbox(sbox_in[31:24]),
		aes_sbox(sbox_in[23:16]),
		aes_sbox(sbox_in[15:8]),
		aes_sbox(sbox_in[7:0])
	};

	// No MixColumns in the final round
	assign rk_col = round_key[127 - 32 * col_idx -: 32];
	assign new_col = (ctrl.last_round ? sbox_out : mix_column(sbox_out)) ^ rk_col;

	// Shadow with the enabled column replaced
	always_comb
	begin
		shadow_next = shadow_q;
		for (int i = 0; i < 4; i++)
			if (ctrl.col_en[i])
				shadow_next[127 - 32 * i -: 32] = new_col;
	end

	always_ff @(posedge clk)
	begin
		if (|ctrl.col_en)
			shadow_q <= shadow_next;
	end

	// ===================================================================
	// State register
	// ===================================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state_q <= '0;
		// CTR encrypts the counter, not the data
		else if (ctrl.load_input)
			state_q <= (mode == CTR) ? iv_in : block_in;
		else if (ctrl.add_key_only)
			state_q <= state_q ^ round_key;
		// Commit picks up column 3 from this same cycle
		else if (ctrl.commit)
			state_q <= shadow_next;
	end

	assign cipher_out = state_q;

endmodule

`default_nettype wire

// File: verilog/aes_core_top.sv
/* AES-128 engine top level
 * Host registers, sequencer, key schedule and datapath
 */
`default_nettype none

module aes_core_top #(
	parameter int ADDR_W = 5
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cyc,
	input  logic              stb,
	input  logic              we,
	input  logic [ADDR_W-1:0] adr,
	input  logic [31:0]       dat_w,
	output logic [31:0]       dat_r,
	output logic              ack
);
	import aes_pkg::*;

	// Register file and core handshake
	logic start;
	logic disable_core;
	aes_mode_e mode;
	logic [127:0] block_in;
	logic [127:0] key_in;
	logic [127:0] iv_in;
	logic end_comp;
	logic iv_cnt_en;
	logic [127:0] cipher_out;

	// Inside the core
	aes_ctrl_t ctrl;
	logic [127:0] round_key;
	logic [31:0] g_word;
	logic [31:0] sbox_out;

	aes_host_regs #(
		.ADDR_W(ADDR_W)
	) u_host_regs (
		.clk(clk),
		.rst_n(rst_n),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.end_comp(end_comp),
		.cipher_out(cipher_out),
		.iv_cnt_en(iv_cnt_en),
		.dat_r(dat_r),
		.ack(ack),
		.start(start),
		.disable_core(disable_core),
		.mode(mode),
		.block_in(block_in),
		.key_in(key_in),
		.iv_in(iv_in)
	);

	aes_control_unit u_control_unit (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.disable_core(disable_core),
		.mode(mode),
		.ctrl(ctrl),
		.end_comp(end_comp),
		.iv_cnt_en(iv_cnt_en)
	);

	aes_key_schedule u_key_schedule (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.key_in(key_in),
		.sbox_out(sbox_out),
		.round_key(round_key),
		.g_word(g_word)
	);

	aes_round_datapath u_round_datapath (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl),
		.block_in(block_in),
		.iv_in(iv_in),
		.mode(mode),
		.round_key(round_key),
		.g_word(g_word),
		.sbox_out(sbox_out),
		.cipher_out(cipher_out)
	);

endmodule

`default_nettype wire

// File: tb/tb_aes_checker.sv
/* AES engine bound checker
 * Wishbone handshake, fixed latency and counter pulse properties
 */
`default_nettype none

module tb_aes_checker (
	input logic clk,
	input logic rst_n,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic start,
	input logic disable_core,
	input logic end_comp,
	input logic iv_cnt_en
);
	timeunit 1ns;
	timeprecision 100ps;

	// Failed assertions, polled by the testbench
	int fail_count;

	initial
	begin
		fail_count = 0;
	end

	// Ack only answers a request from the previous cycle
	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		ack |-> $past(cyc && stb))
	else
	begin
		fail_count = fail_count + 1;
		$error("ack without a preceding request");
	end

	// Single-cycle ack
	ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		ack |=> !ack)
	else
	begin
		fail_count = fail_count + 1;
		$error("ack high on two consecutive cycles");
	end

	// Fixed latency, an abort cancels the pending attempt
	start_to_end: assert property (@(posedge clk) disable iff (!rst_n || disable_core)
		start |-> ##52 end_comp)
	else
	begin
		fail_count = fail_count + 1;
		$error("end_comp did not follow start by 52 cycles");
	end

	end_after_start: assert property (@(posedge clk) disable iff (!rst_n)
		end_comp |-> $past(start, 52))
	else
	begin
		fail_count = fail_count + 1;
		$error("end_comp without a start 52 cycles before");
	end

	// Counter step only on completion
	iv_step_at_end: assert property (@(posedge clk) disable iff (!rst_n)
		iv_cnt_en |-> end_comp)
	else
	begin
		fail_count = fail_count + 1;
		$error("iv_cnt_en outside end_comp");
	end

endmodule

bind aes_core_top tb_aes_checker chk_i (
	.clk(clk),
	.rst_n(rst_n),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.start(start),
	.disable_core(disable_core),
	.end_comp(end_comp),
	.iv_cnt_en(iv_cnt_en)
);

`default_nettype wire

// File: tb/tb_aes.sv
/* AES engine testbench
 * Wishbone host tasks, reference AES-128 model, random ECB and CTR runs
 */
`default_nettype none

module tb_aes;
	timeunit 1ns;
	timeprecision 100ps;

	import aes_pkg::*;

	localparam int ADDR_W = 5;
	localparam int ACK_TIMEOUT = 20;
	localparam int DONE_TIMEOUT = 60;

	logic clk;
	logic rst_n;
	logic cyc;
	logic stb;
	logic we;
	logic [ADDR_W-1:0] adr;
	logic [31:0] dat_w;
	logic [31:0] dat_r;
	logic ack;

	aes_core_top #(
		.ADDR_W(ADDR_W)
	) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack)
	);

	initial
	begin
		clk = 1'b0;
	end

	// 4 ns period
	always #2 clk = ~clk;

	// ===================================================================
	// Reporting
	// ===================================================================
	task automatic check(input logic [127:0] got, input logic [127:0] exp, input string msg);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
			$display(">>> FAIL");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t: %s", $time, what);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	// Stop at the first bound assertion that fires
	always @(negedge clk)
	begin
		if (dut_i.chk_i.fail_count != 0)
		begin
			$display("bound assertion failed at %0t", $time);
			$display(">>> FAIL");
			$fatal(1);
		end
	end

	// ===================================================================
	// Wishbone master
	// ===================================================================
	task automatic wb_cycle(input logic wr, input logic [4:0] a, input logic [31:0] d,
		output logic [31:0] q);
		int n;
		n = 0;
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= wr;
		adr <= ADDR_W'(a);
		dat_w <= d;
		// Ack sampled mid-cycle, away from the edge
		@(negedge clk);
		while (!ack)
		begin
			if (n == ACK_TIMEOUT)
				report_timeout("no ack from the Wishbone slave");
			n++;
			@(negedge clk);
		end
		q = dat_r;
		@(posedge clk);
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
	endtask

	task automatic wb_write(input logic [4:0] a, input logic [31:0] d);
		logic [31:0] unused;
		wb_cycle(1'b1, a, d, unused);
	endtask

	task automatic wb_read(input logic [4:0] a, output logic [31:0] q);
		wb_cycle(1'b0, a, 32'd0, q);
	endtask

	// Word 0 carries bits 127:96
	task automatic write_block(input logic [4:0] base, input logic [127:0] v);
		for (int i = 0; i < 4; i++)
			wb_write(5'(base + i), v[127 - 32 * i -: 32]);
	endtask

	task automatic read_block(input logic [4:0] base, output logic [127:0] v);
		logic [31:0] w;
		for (int i = 0; i < 4; i++)
		begin
			wb_read(5'(base + i), w);
			v[127 - 32 * i -: 32] = w;
		end
	endtask

	// Poll SR until done
	task automatic wait_done();
		logic [31:0] sr;
		int n;
		n = 0;
		wb_read(REG_SR, sr);
		while (!sr[1])
		begin
			if (n == DONE_TIMEOUT)
				report_timeout("engine never reported done");
			n++;
			wb_read(REG_SR, sr);
		end
	endtask

	task automatic run_block(input logic [1:0] m, output logic [127:0] dout);
		wb_write(REG_CR, {28'd0, m, 2'b01});
		wait_done();
		read_block(REG_DOUT0, dout);
	endtask

	// ===================================================================
	// Reference AES-128 model
	// ===================================================================
	function automatic logic [7:0] mul2(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [127:0] ref_encrypt(input logic [127:0] key,
		input logic [127:0] pt);
		logic [127:0] s;
		logic [127:0] t;
		logic [127:0] rk;
		logic [31:0] g;
		logic [7:0] rcon;
		logic [7:0] a [4];
		s = pt ^ key;
		rk = key;
		rcon = 8'h01;
		for (int round = 1; round <= 10; round++)
		begin
			// RotWord, SubWord, Rcon then the word chain
			g = {aes_sbox(rk[23:16]), aes_sbox(rk[15:8]), aes_sbox(rk[7:0]),
				aes_sbox(rk[31:24])};
			g[31:24] = g[31:24] ^ rcon;
			rk[127:96] = rk[127:96] ^ g;
			rk[95:64] = rk[95:64] ^ rk[127:96];
			rk[63:32] = rk[63:32] ^ rk[95:64];
			rk[31:0] = rk[31:0] ^ rk[63:32];
			rcon = mul2(rcon);
			// SubBytes with ShiftRows on byte 4c+r
			for (int c = 0; c < 4; c++)
				for (int r = 0; r < 4; r++)
					t[127 - 8 * (4 * c + r) -: 8] =
						aes_sbox(s[127 - 8 * (4 * ((c + r) % 4) + r) -: 8]);
			// MixColumns except in the final round
			if (round < 10)
			begin
				for (int c = 0; c < 4; c++)
				begin
					for (int r = 0; r < 4; r++)
						a[r] = t[127 - 8 * (4 * c + r) -: 8];
					for (int r = 0; r < 4; r++)
						t[127 - 8 * (4 * c + r) -: 8] = mul2(a[r]) ^ mul2(a[(r + 1) % 4]) ^
							a[(r + 1) % 4] ^ a[(r + 2) % 4] ^ a[(r + 3) % 4];
				end
			end
			s = t ^ rk;
		end
		return s;
	endfunction

	function automatic logic [127:0] rand128();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// ===================================================================
	// Stimulus
	// ===================================================================
	initial
	begin
		logic [31:0] w;
		logic [127:0] key;
		logic [127:0] din;
		logic [127:0] iv;
		logic [127:0] dout;
		logic [127:0] prev;
		logic [127:0] v;
		void'($urandom(32'h120e_519e));
		rst_n = 1'b0;
		cyc <= 1'b0;
		stb <= 1'b0;
		we <= 1'b0;
		adr <= '0;
		dat_w <= '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		// FIPS-197 appendix C.1
		key = 128'h000102030405060708090a0b0c0d0e0f;
		din = 128'h00112233445566778899aabbccddeeff;
		check(ref_encrypt(key, din), 128'h69c4e0d86a7b0430d8cdb78070b4c55a, "model vector");
		write_block(REG_KEY0, key);
		write_block(REG_DIN0, din);
		run_block(ECB, dout);
		check(dout, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, "known vector DOUT");
		wb_read(REG_SR, w);
		check(w, 32'h2, "SR after known vector");

		// Random ECB
		for (int n = 0; n < 40; n++)
		begin
			key = rand128();
			din = rand128();
			write_block(REG_KEY0, key);
			write_block(REG_DIN0, din);
			run_block(ECB, dout);
			check(dout, ref_encrypt(key, din), "random ECB DOUT");
		end

		// Low CTR word near the top so the carry crosses words
		key = rand128();
		iv = rand128();
		iv[31:0] = 32'hffff_fffe;
		write_block(REG_KEY0, key);
		write_block(REG_IV0, iv);
		for (int n = 0; n < 4; n++)
		begin
			din = rand128();
			write_block(REG_DIN0, din);
			run_block(CTR, dout);
			check(dout, din ^ ref_encrypt(key, iv + 128'(n)), "CTR DOUT");
			read_block(REG_IV0, v);
			check(v, iv + 128'(n + 1), "CTR counter readback");
		end
		// All ones wraps to zero
		iv = '1;
		din = rand128();
		write_block(REG_IV0, iv);
		write_block(REG_DIN0, din);
		run_block(CTR, dout);
		check(dout, din ^ ref_encrypt(key, iv), "CTR DOUT at wrap");
		read_block(REG_IV0, v);
		check(v, 128'd0, "CTR counter wrap");

		// Writes and a second start while busy
		key = rand128();
		din = rand128();
		write_block(REG_KEY0, key);
		write_block(REG_DIN0, din);
		wb_write(REG_CR, 32'h1);
		wb_read(REG_SR, w);
		check(w[0], 1'b1, "busy after start");
		wb_write(REG_DIN0, $urandom());
		wb_write(REG_KEY0, $urandom());
		wb_write(REG_CR, 32'h1);
		wait_done();
		read_block(REG_DOUT0, dout);
		check(dout, ref_encrypt(key, din), "DOUT with writes while busy");
		wb_read(REG_DIN0, w);
		check(w, din[127:96], "DIN0 kept while busy");
		wb_read(REG_KEY0, w);
		check(w, key[127:96], "KEY0 kept while busy");

		// Abort mid-computation
		prev = dout;
		key = rand128();
		din = rand128();
		write_block(REG_KEY0, key);
		write_block(REG_DIN0, din);
		wb_write(REG_CR, 32'h1);
		wb_write(REG_CR, 32'h2);
		wb_read(REG_SR, w);
		check(w, 32'h0, "SR right after abort");
		// Long enough for any stray completion
		repeat (80) @(posedge clk);
		wb_read(REG_SR, w);
		check(w, 32'h0, "SR long after abort");
		read_block(REG_DOUT0, dout);
		check(dout, prev, "DOUT kept after abort");

		// Start and reserved bits of CR read back as zero
		wb_write(REG_CR, 32'hffff_fffb);
		wb_read(REG_CR, w);
		check(w, 32'h0000_000a, "CR readback with disable");
		wb_write(REG_CR, 32'h0);
		wb_write(REG_CR, 32'hffff_fff1);
		wb_read(REG_CR, w);
		check(w, 32'h0, "CR readback after start");
		wait_done();
		read_block(REG_DOUT0, dout);
		check(dout, ref_encrypt(key, din), "DOUT after restart");

		// KEY and IV readback
		key = rand128();
		iv = rand128();
		write_block(REG_KEY0, key);
		write_block(REG_IV0, iv);
		read_block(REG_KEY0, v);
		check(v, key, "KEY readback");
		read_block(REG_IV0, v);
		check(v, iv, "IV readback");

		repeat (4) @(posedge clk);
		if (dut_i.chk_i.fail_count != 0)
		begin
			$display("bound assertions failed during the run");
			$display(">>> FAIL");
			$fatal(1);
		end
		else
		begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: tb.f
verilog/aes_pkg.sv
verilog/aes_host_regs.sv
verilog/aes_control_unit.sv
verilog/aes_key_schedule.sv
verilog/aes_round_datapath.sv
verilog/aes_core_top.sv
tb/tb_aes_checker.sv
tb/tb_aes.sv
